//--- thumb_decode.f
+incdir+bench
hdl/thumb_pkg.sv
hdl/imm_gen.sv
hdl/ctrl_decode.sv
hdl/branch_target.sv
hdl/thumb_decode_top.sv
bench/thumb_decode_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = thumb_decode_tb
FILELIST = thumb_decode.f
BUILD    = obj_dir
LOG      = sim.log

SOURCES  = $(shell grep -v '^+' $(FILELIST)) bench/thumb_ref.svh
BIN      = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/thumb_ref.svh
`ifndef THUMB_REF_SVH
`define THUMB_REF_SVH

// expected results, worked out from the Thumb encoding rules
// each function sees the current halfword, the last strobed halfword, whether that one
// was a branch-with-link first half, and the PC of the current halfword plus 4

// a second half only counts when a first half was the last strobed halfword
function automatic logic is_pair(instr_u cur, logic first_seen);
    return first_seen && (cur.raw[15:14] == 2'b11) && cur.raw[12];
endfunction

function automatic logic [WORD-1:0] ref_imm(instr_u cur, instr_u prev, logic first_seen,
                                            logic [WORD-1:0] pc);
    logic [15:0] h;
    logic        s;
    logic [24:0] off;
    h = cur.raw;
    s = prev.raw[10];
    if (is_pair(cur, first_seen)) begin
        off = {s, ~(h[13] ^ s), ~(h[11] ^ s), prev.raw[9:0], h[10:0], 1'b0};
        return {{7{off[24]}}, off} - 32'd2;
    end
    casez (h[15:10])
        6'b00????: begin
            if (h[13]) begin
                return {24'd0, h[7:0]};
            end else if (h[13:11] == 3'b011) begin
                // register add and subtract have no immediate
                return h[10] ? {29'd0, h[8:6]} : 32'd0;
            end
            return {27'd0, h[10:6]};
        end
        6'b01001?: return {22'd0, h[7:0], 2'b00} + 32'd4;
        6'b0110??: return {25'd0, h[10:6], 2'b00};
        6'b0111??: return {27'd0, h[10:6]};
        6'b1000??: return {26'd0, h[10:6], 1'b0};
        6'b1001??,
        6'b1010??: return {22'd0, h[7:0], 2'b00};
        6'b1011??: return (h[11:8] == 4'b0000) ? {23'd0, h[6:0], 2'b00} : 32'd0;
        6'b1101??: return {{23{h[7]}}, h[7:0], 1'b0};
        6'b11100?: return {{20{h[10]}}, h[10:0], 1'b0};
        default:   return 32'd0;
    endcase
endfunction

function automatic ctrl_t ref_ctrl(instr_u cur, instr_u prev, logic first_seen,
                                   logic [WORD-1:0] pc);
    logic [15:0] h;
    ctrl_t       c;
    h             = cur.raw;
    c             = '0;
    c.iclass      = ICLASS_OTHER;
    c.cond        = 4'b1110;
    c.pair_second = is_pair(cur, first_seen);
    if (c.pair_second) begin
        c.iclass   = ICLASS_BRANCH_LINK;
        c.uses_imm = 1'b1;
        return c;
    end
    casez (h[15:10])
        6'b00????: begin
            c.uses_imm = 1'b1;
            c.iclass   = ICLASS_ALU_IMM;
            c.rd       = h[2:0];
            c.rn       = h[5:3];
            if (h[13:10] == 4'b0110) begin
                c.uses_imm = 1'b0;
                c.iclass   = ICLASS_ALU_REG;
            end else if (h[13]) begin
                c.rd = h[10:8];
                c.rn = h[10:8];
            end
        end
        6'b010000: begin
            c.rd       = h[2:0];
            c.rn       = h[5:3];
            c.uses_imm = (h[9:6] == 4'b1001);
            c.iclass   = c.uses_imm ? ICLASS_ALU_IMM : ICLASS_ALU_REG;
        end
        6'b01001?: begin
            c.iclass   = ICLASS_LOAD;
            c.rd       = h[10:8];
            c.uses_imm = 1'b1;
        end
        6'b0110??,
        6'b0111??,
        6'b1000??: begin
            c.iclass   = h[11] ? ICLASS_LOAD : ICLASS_STORE;
            c.rd       = h[2:0];
            c.rn       = h[5:3];
            c.uses_imm = 1'b1;
        end
        6'b1001??: begin
            c.iclass   = h[11] ? ICLASS_LOAD : ICLASS_STORE;
            c.rd       = h[10:8];
            c.uses_imm = 1'b1;
        end
        6'b1010??: begin
            c.iclass   = ICLASS_ADDR_GEN;
            c.rd       = h[10:8];
            c.uses_imm = 1'b1;
        end
        6'b1011??: begin
            if (h[11:8] == 4'b0000) begin
                c.iclass   = ICLASS_ALU_IMM;
                c.uses_imm = 1'b1;
            end
        end
        6'b1101??: begin
            c.iclass   = ICLASS_BRANCH_COND;
            c.cond     = h[11:8];
            c.uses_imm = 1'b1;
        end
        6'b11100?: begin
            c.iclass   = ICLASS_BRANCH;
            c.uses_imm = 1'b1;
        end
        default: begin
            c.iclass = ICLASS_OTHER;
        end
    endcase
    return c;
endfunction

function automatic target_t ref_targets(instr_u cur, instr_u prev, logic first_seen,
                                        logic [WORD-1:0] pc);
    ctrl_t   c;
    target_t t;
    c = ref_ctrl(cur, prev, first_seen, pc);
    t = '0;
    if (c.iclass inside {ICLASS_BRANCH_COND, ICLASS_BRANCH, ICLASS_BRANCH_LINK}) begin
        t.target = pc + ref_imm(cur, prev, first_seen, pc);
    end
    if (c.iclass == ICLASS_BRANCH_LINK) begin
        // return address is just past the second half, in Thumb state
        t.link = (pc - 32'd2) | 32'd1;
    end
    return t;
endfunction

`endif

//--- bench/thumb_decode_tb.sv
`timescale 1ns/1ns

module thumb_decode_tb import thumb_pkg::*; ();

    localparam logic [31:0] SEED = 32'hed6a4703;
    localparam int N_ALU    = 150;
    localparam int N_MEM    = 150;
    localparam int N_BRANCH = 150;
    localparam int N_PAIR   = 40;
    localparam int N_MIX    = 500;
    // a pair takes at most five cycles with its longest idle gap
    localparam int TOTAL_CYCLES = 4 + 1 + N_ALU + N_MEM + N_BRANCH + 5 * N_PAIR + N_MIX + 2;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 40 + 40 * 50;

    logic            clk_i;
    logic            rst_n_i;
    instr_u          instr_i;
    logic            instr_valid_i;
    logic [WORD-1:0] pc_i;
    logic [WORD-1:0] imm_o;
    ctrl_t           ctrl_o;
    target_t         targets_o;

    // model of the decoder state, updated on every strobed halfword
    instr_u last_half;
    logic   pending;
    string  test_name;
    int     checks_done;

    `include "thumb_ref.svh"

    thumb_decode_top DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .imm_o         (imm_o),
        .ctrl_o        (ctrl_o),
        .targets_o     (targets_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_imm(input string name, input logic [WORD-1:0] exp,
                             input logic [WORD-1:0] act);
        if (exp !== act) begin
            fail_stop($sformatf("FAILED %s imm expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (exp !== act) begin
            fail_stop($sformatf("FAILED %s ctrl expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_targets(input string name, input target_t exp, input target_t act);
        if (exp !== act) begin
            fail_stop($sformatf("FAILED %s targets expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic drive(input logic [15:0] raw, input logic valid, input logic [WORD-1:0] pc,
                         input string name);
        @(posedge clk_i);
        test_name     = name;
        instr_i.raw   <= raw;
        instr_valid_i <= valid;
        pc_i          <= pc;
    endtask

    function automatic logic [15:0] rand_half();
        return 16'($urandom());
    endfunction

    function automatic logic [WORD-1:0] rand_pc();
        return $urandom() & 32'hffff_fffe;
    endfunction

    // shift, add, subtract, move, compare and reverse subtract forms
    function automatic logic [15:0] alu_half();
        logic [15:0] h;
        h = rand_half();
        if ($urandom_range(0, 3) == 0) begin
            h[15:6] = 10'b0100001001;
        end else begin
            h[15:14] = 2'b00;
        end
        return h;
    endfunction

    function automatic logic [15:0] mem_half();
        logic [15:0] h;
        h = rand_half();
        case ($urandom_range(0, 6))
            0:       h[15:11] = 5'b01001;
            1:       h[15:12] = 4'b0110;
            2:       h[15:12] = 4'b0111;
            3:       h[15:12] = 4'b1000;
            4:       h[15:12] = 4'b1001;
            5:       h[15:12] = 4'b1010;
            default: h[15:8]  = 8'b10110000;
        endcase
        return h;
    endfunction

    function automatic logic [15:0] branch_half();
        logic [15:0] h;
        h = rand_half();
        if ($urandom_range(0, 1) == 0) begin
            h[15:12] = 4'b1101;
        end else begin
            h[15:11] = 5'b11100;
        end
        return h;
    endfunction

    task automatic send_pair(input int gap);
        logic [15:0]     first;
        logic [15:0]     second;
        logic [WORD-1:0] pc;
        first          = rand_half();
        first[15:11]   = 5'b11110;
        second         = rand_half();
        second[15:14]  = 2'b11;
        second[12]     = 1'b1;
        pc             = rand_pc();
        drive(first, 1'b1, pc, "bl_pair");
        // idle cycles carry garbage that must not disturb the stored first half
        repeat (gap) drive(rand_half(), 1'b0, rand_pc(), "bl_pair");
        drive(second, 1'b1, pc + 32'd2, "bl_pair");
    endtask

    initial begin : compare_outputs
        logic [WORD-1:0] exp_imm;
        ctrl_t           exp_ctrl;
        target_t         exp_targets;
        last_half   = '0;
        pending     = 1'b0;
        checks_done = 0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && instr_valid_i) begin
                exp_imm     = ref_imm(instr_i, last_half, pending, pc_i);
                exp_ctrl    = ref_ctrl(instr_i, last_half, pending, pc_i);
                exp_targets = ref_targets(instr_i, last_half, pending, pc_i);
                check_imm(test_name, exp_imm, imm_o);
                check_ctrl(test_name, exp_ctrl, ctrl_o);
                check_targets(test_name, exp_targets, targets_o);
                checks_done = checks_done + 1;
                last_half   = instr_i;
                pending     = (instr_i.raw[15:11] == 5'b11110);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired before the tests finished");
    end

    initial begin : stimulus
        logic [15:0] h;
        logic        valid;
        int unsigned sel;
        void'($urandom(SEED));
        rst_n_i       = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        pc_i          = '0;
        test_name     = "reset";
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // a lone second half straight after reset must not pair up
        h        = rand_half();
        h[15:11] = 5'b11111;
        drive(h, 1'b1, rand_pc(), "reset_no_pair");

        for (int i = 0; i < N_ALU; i++) begin
            drive(alu_half(), 1'b1, rand_pc(), "alu_imm");
        end
        for (int i = 0; i < N_MEM; i++) begin
            drive(mem_half(), 1'b1, rand_pc(), "mem_scaled");
        end
        for (int i = 0; i < N_BRANCH; i++) begin
            drive(branch_half(), 1'b1, rand_pc(), "branch_offset");
        end
        // gaps of zero to three idle cycles in turn, so back-to-back pairs always occur
        for (int i = 0; i < N_PAIR; i++) begin
            send_pair(i % 4);
        end

        // mixed stream, biased toward branch-with-link halves
        for (int i = 0; i < N_MIX; i++) begin
            h   = rand_half();
            sel = $urandom_range(0, 7);
            if (sel == 0) begin
                h[15:11] = 5'b11110;
            end else if (sel == 1) begin
                h[15:14] = 2'b11;
                h[12]    = 1'b1;
            end
            valid = ($urandom_range(0, 3) != 0);
            drive(h, valid, rand_pc(), "mixed_stream");
        end

        drive(16'h0000, 1'b0, 32'd0, "idle");
        @(negedge clk_i);
        if (checks_done == 0) begin
            fail_stop("no valid cycle was ever checked");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- hdl/thumb_decode_top.sv
`timescale 1ns/1ns

module thumb_decode_top import thumb_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  instr_u          instr_i,
    input  logic            instr_valid_i,
    input  logic [WORD-1:0] pc_i,
    output logic [WORD-1:0] imm_o,
    output ctrl_t           ctrl_o,
    output target_t         targets_o
);

    logic [WORD-1:0] imm;
    ctrl_t           ctrl;

    // immediate extraction, keeps its own copy of the previous halfword
    imm_gen u_imm_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .imm_o         (imm)
    );

    // classification and pair tracking
    ctrl_decode u_ctrl_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .ctrl_o        (ctrl)
    );

    branch_target u_branch_target (
        .pc_i      (pc_i),
        .imm_i     (imm),
        .iclass_i  (ctrl.iclass),
        .targets_o (targets_o)
    );

    assign imm_o  = imm;
    assign ctrl_o = ctrl;

endmodule

//--- hdl/branch_target.sv
`timescale 1ns/1ns

module branch_target import thumb_pkg::*; (
    input  logic [WORD-1:0] pc_i,
    input  logic [WORD-1:0] imm_i,
    input  iclass_t         iclass_i,
    output target_t         targets_o
);

    logic [WORD-1:0] sum;
    logic [WORD-1:0] return_addr;

    // pc_i already runs 4 bytes ahead of the current halfword, so the offset applies directly
    assign sum = pc_i + imm_i;

    // the link points just past the second half, with bit 0 set to stay in Thumb state
    assign return_addr = (pc_i - HALFWORD_OFFSET) | WORD'(1);

    always_comb begin
        targets_o = '0;
        case (iclass_i)
            ICLASS_BRANCH_COND,
            ICLASS_BRANCH: begin
                targets_o.target = sum;
            end
            ICLASS_BRANCH_LINK: begin
                targets_o.target = sum;
                targets_o.link   = return_addr;
            end
            default: begin
                // classes that do not change flow report nothing
                targets_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/ctrl_decode.sv
`timescale 1ns/1ns

module ctrl_decode import thumb_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  instr_u instr_i,
    input  logic   instr_valid_i,
    output ctrl_t  ctrl_o
);

    opcode_t op;
    logic    is_first_half;
    logic    pending_first;
    logic    pair_second;

    assign op            = instr_i.raw[15:10];
    assign is_first_half = (instr_i.jump_v.op == BL_FIRST_HALF);
    assign pair_second   = pending_first && (instr_i.jump_v.op ==? BL_SECOND_HALF);

    // set by a strobed first half, cleared by any other strobed halfword
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_first <= 1'b0;
        end else if (instr_valid_i) begin
            pending_first <= is_first_half;
        end
    end

    always_comb begin
        ctrl_o             = '0;
        ctrl_o.iclass      = ICLASS_OTHER;
        ctrl_o.cond        = 4'b1110;
        ctrl_o.pair_second = pair_second;

        if (pair_second) begin
            ctrl_o.iclass   = ICLASS_BRANCH_LINK;
            ctrl_o.uses_imm = 1'b1;
        end else begin
            casez (op)
                SHIFT_IMM: begin
                    casez (instr_i.raw[13:9])
                        LEFT_SHIFT_L_IM,
                        RIGHT_SHIFT_L_IM,
                        RIGHT_SHIFT_A_IM,
                        ADD_3_IMM,
                        SUB_3_IMM: begin
                            ctrl_o.iclass   = ICLASS_ALU_IMM;
                            ctrl_o.rd       = instr_i.shift_v.rd;
                            ctrl_o.rn       = instr_i.shift_v.rm;
                            ctrl_o.uses_imm = 1'b1;
                        end
                        MOV_8_IMM,
                        CMP_8_IMM,
                        ADD_8_IMM,
                        SUB_8_IMM: begin
                            // one register is both source and destination here
                            ctrl_o.iclass   = ICLASS_ALU_IMM;
                            ctrl_o.rd       = instr_i.imm8_v.rd;
                            ctrl_o.rn       = instr_i.imm8_v.rd;
                            ctrl_o.uses_imm = 1'b1;
                        end
                        default: begin
                            ctrl_o.iclass = ICLASS_ALU_REG;
                            ctrl_o.rd     = instr_i.shift_v.rd;
                            ctrl_o.rn     = instr_i.shift_v.rm;
                        end
                    endcase
                end
                DATA_PROCESSING: begin
                    ctrl_o.rd = instr_i.shift_v.rd;
                    ctrl_o.rn = instr_i.shift_v.rm;
                    if (instr_i.raw[9:6] == REVERSE_SUB) begin
                        ctrl_o.iclass   = ICLASS_ALU_IMM;
                        ctrl_o.uses_imm = 1'b1;
                    end else begin
                        ctrl_o.iclass = ICLASS_ALU_REG;
                    end
                end
                LOAD_LITERAL: begin
                    ctrl_o.iclass   = ICLASS_LOAD;
                    ctrl_o.rd       = instr_i.imm8_v.rd;
                    ctrl_o.uses_imm = 1'b1;
                end
                LOAD_STORE_IMM,
                LOAD_STORE_BYTE,
                LOAD_STORE_HW: begin
                    // bit 11 separates the load from the store
                    ctrl_o.iclass   = instr_i.raw[11] ? ICLASS_LOAD : ICLASS_STORE;
                    ctrl_o.rd       = instr_i.shift_v.rd;
                    ctrl_o.rn       = instr_i.shift_v.rm;
                    ctrl_o.uses_imm = 1'b1;
                end
                LOAD_STORE_SP_R: begin
                    ctrl_o.iclass   = instr_i.raw[11] ? ICLASS_LOAD : ICLASS_STORE;
                    ctrl_o.rd       = instr_i.imm8_v.rd;
                    ctrl_o.uses_imm = 1'b1;
                end
                GEN_PC_REL,
                GEN_SP_REL: begin
                    ctrl_o.iclass   = ICLASS_ADDR_GEN;
                    ctrl_o.rd       = instr_i.imm8_v.rd;
                    ctrl_o.uses_imm = 1'b1;
                end
                MIS_16_BIT: begin
                    if ((instr_i.raw[11:5] ==? ADD_IMM_SP) ||
                        (instr_i.raw[11:5] ==? SUB_IMM_SP)) begin
                        ctrl_o.iclass   = ICLASS_ALU_IMM;
                        ctrl_o.uses_imm = 1'b1;
                    end
                end
                COND_BRANCH: begin
                    ctrl_o.iclass   = ICLASS_BRANCH_COND;
                    ctrl_o.cond     = instr_i.cond_v.cond;
                    ctrl_o.uses_imm = 1'b1;
                end
                UNCOND_BRANCH: begin
                    ctrl_o.iclass   = ICLASS_BRANCH;
                    ctrl_o.uses_imm = 1'b1;
                end
                SPECIAL,
                TWO_WORD_INST_1,
                TWO_WORD_INST_2,
                TWO_WORD_INST_3: begin
                    ctrl_o.iclass = ICLASS_OTHER;
                end
                default: begin
                    ctrl_o.iclass = ICLASS_OTHER;
                end
            endcase
        end
    end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen import thumb_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  instr_u          instr_i,
    input  logic            instr_valid_i,
    output logic [WORD-1:0] imm_o
);

    opcode_t     op;
    // last strobed halfword, which holds the upper offset bits of a branch-with-link pair
    instr_u      prev_half;
    logic        pair_second;
    logic        sign;
    logic        i1;
    logic        i2;
    logic [24:0] bl_offset;

    assign op = instr_i.raw[15:10];

    // only a strobed halfword is kept, so idle cycles between the halves are harmless
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_half <= '0;
        end else if (instr_valid_i) begin
            prev_half <= instr_i;
        end
    end

    // assemble the pair offset
    // I1 and I2 are the J bits of the second half folded with the sign bit of the first
    always_comb begin
        sign        = prev_half.raw[10];
        i1          = ~(instr_i.raw[13] ^ sign);
        i2          = ~(instr_i.raw[11] ^ sign);
        bl_offset   = {sign, i1, i2, prev_half.raw[9:0], instr_i.jump_v.imm11, 1'b0};
        pair_second = (prev_half.jump_v.op == BL_FIRST_HALF) &&
                      (instr_i.jump_v.op ==? BL_SECOND_HALF);
    end

    always_comb begin
        imm_o = '0;
        if (pair_second) begin
            // the PC seen here belongs to the second half, so step back to the first one
            imm_o = WORD'(signed'(bl_offset)) - HALFWORD_OFFSET;
        end else begin
            casez (op)
                SHIFT_IMM: begin
                    casez (instr_i.raw[13:9])
                        LEFT_SHIFT_L_IM,
                        RIGHT_SHIFT_L_IM,
                        RIGHT_SHIFT_A_IM: imm_o = WORD'(instr_i.shift_v.imm5);
                        ADD_3_IMM,
                        SUB_3_IMM:        imm_o = WORD'(instr_i.raw[8:6]);
                        MOV_8_IMM,
                        CMP_8_IMM,
                        ADD_8_IMM,
                        SUB_8_IMM:        imm_o = WORD'(instr_i.imm8_v.imm8);
                        // add and subtract register forms carry no immediate
                        default:          imm_o = '0;
                    endcase
                end
                DATA_PROCESSING: begin
                    // a reverse subtract takes its operand from zero, every other form is
                    // register only
                    imm_o = '0;
                end
                SPECIAL: begin
                    imm_o = '0;
                end
                LOAD_LITERAL: begin
                    imm_o = WORD'({instr_i.imm8_v.imm8, 2'b00}) + PC_AHEAD;
                end
                LOAD_STORE_IMM: begin
                    imm_o = WORD'({instr_i.shift_v.imm5, 2'b00});
                end
                LOAD_STORE_BYTE: begin
                    imm_o = WORD'(instr_i.shift_v.imm5);
                end
                LOAD_STORE_HW: begin
                    imm_o = WORD'({instr_i.shift_v.imm5, 1'b0});
                end
                LOAD_STORE_SP_R,
                GEN_PC_REL,
                GEN_SP_REL: begin
                    imm_o = WORD'({instr_i.imm8_v.imm8, 2'b00});
                end
                MIS_16_BIT: begin
                    casez (instr_i.raw[11:5])
                        ADD_IMM_SP,
                        SUB_IMM_SP: imm_o = WORD'({instr_i.raw[6:0], 2'b00});
                        default:    imm_o = '0;
                    endcase
                end
                COND_BRANCH: begin
                    imm_o = WORD'(signed'({instr_i.cond_v.imm8, 1'b0}));
                end
                UNCOND_BRANCH: begin
                    imm_o = WORD'(signed'({instr_i.jump_v.imm11, 1'b0}));
                end
                TWO_WORD_INST_1,
                TWO_WORD_INST_2,
                TWO_WORD_INST_3: begin
                    // a lone half of a 32-bit instruction has nothing to offer yet
                    imm_o = '0;
                end
                default: begin
                    imm_o = '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/thumb_pkg.sv
package thumb_pkg;

    // data and instruction widths
    localparam int WORD      = 32;
    localparam int HALF_WORD = 16;

    // the PC seen by the second half of a pair is two bytes past the start of the pair
    localparam logic [WORD-1:0] HALFWORD_OFFSET = 32'd2;

    // literal loads see the PC of the current halfword plus 4
    localparam logic [WORD-1:0] PC_AHEAD = 32'd4;

    // major opcode taken from bits 15 to 10
    typedef logic [5:0] opcode_t;

    localparam opcode_t SHIFT_IMM       = 6'b00????;
    localparam opcode_t DATA_PROCESSING = 6'b010000;
    localparam opcode_t SPECIAL         = 6'b010001;
    localparam opcode_t LOAD_LITERAL    = 6'b01001?;
    localparam opcode_t LOAD_STORE_IMM  = 6'b0110??;
    localparam opcode_t LOAD_STORE_BYTE = 6'b0111??;
    localparam opcode_t LOAD_STORE_HW   = 6'b1000??;
    localparam opcode_t LOAD_STORE_SP_R = 6'b1001??;
    localparam opcode_t GEN_PC_REL      = 6'b10100?;
    localparam opcode_t GEN_SP_REL      = 6'b10101?;
    localparam opcode_t MIS_16_BIT      = 6'b1011??;
    localparam opcode_t COND_BRANCH     = 6'b1101??;
    localparam opcode_t UNCOND_BRANCH   = 6'b11100?;
    localparam opcode_t TWO_WORD_INST_1 = 6'b11101?;
    localparam opcode_t TWO_WORD_INST_2 = 6'b11110?;
    localparam opcode_t TWO_WORD_INST_3 = 6'b11111?;

    // shift, add, subtract, move and compare group, bits 13 to 9
    localparam logic [4:0] LEFT_SHIFT_L_IM  = 5'b000??;
    localparam logic [4:0] RIGHT_SHIFT_L_IM = 5'b001??;
    localparam logic [4:0] RIGHT_SHIFT_A_IM = 5'b010??;
    localparam logic [4:0] ADD_3_IMM        = 5'b01110;
    localparam logic [4:0] SUB_3_IMM        = 5'b01111;
    localparam logic [4:0] MOV_8_IMM        = 5'b100??;
    localparam logic [4:0] CMP_8_IMM        = 5'b101??;
    localparam logic [4:0] ADD_8_IMM        = 5'b110??;
    localparam logic [4:0] SUB_8_IMM        = 5'b111??;

    // data processing group, bits 9 to 6
    localparam logic [3:0] REVERSE_SUB = 4'b1001;

    // miscellaneous group, bits 11 to 5
    localparam logic [6:0] ADD_IMM_SP = 7'b00000??;
    localparam logic [6:0] SUB_IMM_SP = 7'b00001??;

    // branch-with-link halves, matched on bits 15 to 11
    localparam logic [4:0] BL_FIRST_HALF  = 5'b11110;
    localparam logic [4:0] BL_SECOND_HALF = 5'b11?1?;

    typedef struct packed {
        logic [4:0] op;
        logic [4:0] imm5;
        logic [2:0] rm;
        logic [2:0] rd;
    } shift_view_t;

    typedef struct packed {
        logic [4:0] op;
        logic [2:0] rd;
        logic [7:0] imm8;
    } imm8_view_t;

    typedef struct packed {
        logic [3:0] op;
        logic [3:0] cond;
        logic [7:0] imm8;
    } cond_view_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [10:0] imm11;
    } jump_view_t;

    // one halfword read through whichever field layout its opcode calls for
    typedef union packed {
        logic [HALF_WORD-1:0] raw;
        shift_view_t          shift_v;
        imm8_view_t           imm8_v;
        cond_view_t           cond_v;
        jump_view_t           jump_v;
    } instr_u;

    typedef enum logic [3:0] {
        ICLASS_ALU_IMM     = 4'd0,
        ICLASS_ALU_REG     = 4'd1,
        ICLASS_LOAD        = 4'd2,
        ICLASS_STORE       = 4'd3,
        ICLASS_BRANCH_COND = 4'd4,
        ICLASS_BRANCH      = 4'd5,
        ICLASS_BRANCH_LINK = 4'd6,
        ICLASS_ADDR_GEN    = 4'd7,
        ICLASS_OTHER       = 4'd8
    } iclass_t;

    typedef struct packed {
        iclass_t    iclass;
        logic [2:0] rd;
        logic [2:0] rn;
        logic [3:0] cond;
        logic       uses_imm;
        logic       pair_second;
    } ctrl_t;

    typedef struct packed {
        logic [WORD-1:0] target;
        logic [WORD-1:0] link;
    } target_t;

endpackage
